//--- logic/board_io_pkg.sv
`default_nettype none

package board_io_pkg;

	// UART bit timing, 8N1
	localparam int CLKS_PER_BIT = 16;
	localparam int HALF_BIT = CLKS_PER_BIT / 2;
	localparam int BIT_CNT_W = $clog2(CLKS_PER_BIT);
	localparam int DATA_BITS = 8;

	// Seven-segment bank geometry
	localparam int NUM_DIGITS = 8;
	localparam int SEG_W = 7;
	localparam int HEX_W = 4;

	// Board I/O widths
	localparam int KEY_W = 3;
	localparam int SW_W = 18;
	localparam int LEDG_W = 9;

	// Pushbutton roles, bit 0 is KEY1
	localparam int KEY_CLEAR = 0;
	localparam int KEY_LOAD = 1;
	localparam int KEY_SEND = 2;

	typedef logic [DATA_BITS-1:0] uart_byte_t;
	typedef logic [HEX_W-1:0] hex_digit_t;
	// Active low, bit 0 is segment a
	typedef logic [SEG_W-1:0] seg7_t;
	// HEX0 in the lowest bits
	typedef logic [NUM_DIGITS*SEG_W-1:0] hex_bank_t;
	typedef logic [NUM_DIGITS*HEX_W-1:0] digit_reg_t;
	typedef logic [KEY_W-1:0] key_mask_t;
	typedef logic [SW_W-1:0] switch_t;
	typedef logic [BIT_CNT_W-1:0] bit_cnt_t;
	typedef logic [$clog2(DATA_BITS)-1:0] bit_idx_t;

	// Single-cycle strobes, payload only meaningful while valid
	typedef struct packed {
		logic valid;
		uart_byte_t data;
		logic frame_error;
	} rx_event_t;

	typedef struct packed {
		logic valid;
		key_mask_t pressed;
	} key_event_t;

	typedef struct packed {
		logic valid;
		uart_byte_t data;
	} tx_request_t;

	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;
	typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

endpackage

`default_nettype wire

//--- logic/uart_rx_deframer.sv
`timescale 1ns/10ps
`default_nettype none

module uart_rx_deframer (
	input logic clock_50,
	input logic rst_n,
	input logic uart_rxd,
	output board_io_pkg::rx_event_t rx_event
);
	import board_io_pkg::*;

	// Synchronizer chain, line idles high
	logic [1:0] rxd_meta;
	logic rxd_sync;
	// Previous synchronized value for the start edge
	logic rxd_last;

	rx_state_t state;
	bit_cnt_t bit_cnt;
	bit_idx_t bit_idx;
	logic bit_end;

	// Payload
	uart_byte_t shift_q;
	logic frame_err_q;
	logic event_valid;

	assign rxd_sync = rxd_meta[1];
	// Counter at the middle of a data or stop bit
	assign bit_end = (bit_cnt == bit_cnt_t'(CLKS_PER_BIT - 1));

	always_ff @(posedge clock_50) begin
		if (!rst_n) begin
			rxd_meta <= 2'b11;
			rxd_last <= 1'b1;
		end else begin
			rxd_meta <= {rxd_meta[0], uart_rxd};
			rxd_last <= rxd_sync;
		end
	end

	always_ff @(posedge clock_50) begin
		if (!rst_n) begin
			state <= RX_IDLE;
			bit_cnt <= '0;
			bit_idx <= '0;
			event_valid <= 1'b0;
		end else begin
			event_valid <= 1'b0;
			case (state)
				RX_IDLE: begin
					bit_cnt <= '0;
					bit_idx <= '0;
					// Falling edge opens a frame
					if (rxd_last && !rxd_sync) begin
						state <= RX_START;
					end
				end
				RX_START: begin
					if (bit_cnt == bit_cnt_t'(HALF_BIT - 1)) begin
						bit_cnt <= '0;
						// Line back high at half a bit, treat as a glitch
						state <= rxd_sync ? RX_IDLE : RX_DATA;
					end else begin
						bit_cnt <= bit_cnt + 1'b1;
					end
				end
				RX_DATA: begin
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_end) begin
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == bit_idx_t'(DATA_BITS - 1)) begin
							state <= RX_STOP;
						end
					end
				end
				RX_STOP: begin
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_end) begin
						// Event shows up the cycle after the stop sample
						event_valid <= 1'b1;
						state <= RX_IDLE;
					end
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// LSB arrives first, shift in from the top
	always_ff @(posedge clock_50) begin
		if (state == RX_DATA && bit_end) begin
			shift_q <= {rxd_sync, shift_q[DATA_BITS-1:1]};
		end
		if (state == RX_STOP && bit_end) begin
			frame_err_q <= !rxd_sync;
		end
	end

	assign rx_event.valid = event_valid;
	assign rx_event.data = shift_q;
	assign rx_event.frame_error = frame_err_q;

endmodule

`default_nettype wire

//--- logic/key_press_capture.sv
`timescale 1ns/10ps
`default_nettype none

module key_press_capture (
	input logic clock_50,
	input logic rst_n,
	input board_io_pkg::key_mask_t key,
	output board_io_pkg::key_event_t key_event
);
	import board_io_pkg::*;

	// Buttons are active low, released reads as ones
	key_mask_t key_meta;
	key_mask_t key_sync;
	key_mask_t key_last;
	// High to low transitions this cycle
	key_mask_t fall;

	logic press_valid;
	key_mask_t press_mask;

	assign fall = key_last & ~key_sync;

	always_ff @(posedge clock_50) begin
		if (!rst_n) begin
			key_meta <= '1;
			key_sync <= '1;
			key_last <= '1;
			press_valid <= 1'b0;
		end else begin
			// Two synchronizer stages
			key_meta <= key;
			key_sync <= key_meta;
			key_last <= key_sync;
			// Any button pressed raises the strobe
			press_valid <= |fall;
		end
	end

	// Simultaneous presses share one event
	always_ff @(posedge clock_50) begin
		press_mask <= fall;
	end

	assign key_event.valid = press_valid;
	assign key_event.pressed = press_mask;

endmodule

`default_nettype wire

//--- logic/display_controller.sv
`timescale 1ns/10ps
`default_nettype none

module display_controller (
	input logic clock_50,
	input logic rst_n,
	input board_io_pkg::rx_event_t rx_event,
	input board_io_pkg::key_event_t key_event,
	input board_io_pkg::switch_t sw,
	output board_io_pkg::tx_request_t tx_request,
	output board_io_pkg::hex_bank_t hex,
	output logic [board_io_pkg::LEDG_W-1:0] ledg,
	output board_io_pkg::switch_t ledr
);
	import board_io_pkg::*;

	// Active-low hex font, bit 0 is segment a
	function automatic seg7_t seg_decode(input hex_digit_t digit);
		seg7_t seg;
		case (digit)
			4'h0: seg = 7'h40;
			4'h1: seg = 7'h79;
			4'h2: seg = 7'h24;
			4'h3: seg = 7'h30;
			4'h4: seg = 7'h19;
			4'h5: seg = 7'h12;
			4'h6: seg = 7'h02;
			4'h7: seg = 7'h78;
			4'h8: seg = 7'h00;
			4'h9: seg = 7'h10;
			4'ha: seg = 7'h08;
			4'hb: seg = 7'h03;
			4'hc: seg = 7'h46;
			4'hd: seg = 7'h21;
			4'he: seg = 7'h06;
			// F
			default: seg = 7'h0e;
		endcase
		return seg;
	endfunction

	// Eight hex digits, newest byte in the low end
	digit_reg_t digits_q;
	digit_reg_t digits_next;
	// Sticky framing error and last good byte
	logic err_q;
	logic err_next;
	uart_byte_t last_q;
	uart_byte_t last_next;

	logic tx_valid_q;
	logic tx_valid_next;
	uart_byte_t tx_data_q;
	uart_byte_t tx_data_next;
	hex_bank_t hex_next;

	logic key_clear;
	logic key_load;
	logic key_send;
	logic byte_ok;
	logic byte_bad;

	assign key_clear = key_event.valid && key_event.pressed[KEY_CLEAR];
	assign key_load = key_event.valid && key_event.pressed[KEY_LOAD];
	assign key_send = key_event.valid && key_event.pressed[KEY_SEND];
	// Key 1 swallows any byte event in the same cycle
	assign byte_ok = rx_event.valid && !rx_event.frame_error && !key_clear;
	assign byte_bad = rx_event.valid && rx_event.frame_error && !key_clear;

	always_comb begin
		digits_next = digits_q;
		err_next = err_q;
		last_next = last_q;
		tx_valid_next = 1'b0;
		tx_data_next = sw[DATA_BITS-1:0];
		if (key_clear) begin
			digits_next = '0;
			err_next = 1'b0;
		end else begin
			// Oldest byte falls off the top
			if (byte_ok) begin
				digits_next = {digits_q[23:0], rx_event.data};
			end
			// Switch load lands on top of a same-cycle shift
			if (key_load) begin
				digits_next[15:0] = sw[15:0];
			end
		end
		if (byte_bad) begin
			err_next = 1'b1;
		end
		// Echo beats a key 3 request
		if (byte_ok) begin
			last_next = rx_event.data;
			tx_valid_next = 1'b1;
			tx_data_next = rx_event.data;
		end else if (key_send) begin
			tx_valid_next = 1'b1;
		end
		// Decode the next value so segments track the register
		for (int i = 0; i < NUM_DIGITS; i++) begin
			hex_next[i*SEG_W +: SEG_W] = seg_decode(digits_next[i*HEX_W +: HEX_W]);
		end
	end

	always_ff @(posedge clock_50) begin
		if (!rst_n) begin
			digits_q <= '0;
			err_q <= 1'b0;
			last_q <= '0;
			tx_valid_q <= 1'b0;
			ledr <= '0;
			hex <= {NUM_DIGITS{seg_decode(hex_digit_t'(0))}};
		end else begin
			digits_q <= digits_next;
			err_q <= err_next;
			last_q <= last_next;
			tx_valid_q <= tx_valid_next;
			ledr <= sw;
			hex <= hex_next;
		end
	end

	always_ff @(posedge clock_50) begin
		tx_data_q <= tx_data_next;
	end

	assign ledg = {err_q, last_q};
	assign tx_request.valid = tx_valid_q;
	assign tx_request.data = tx_data_q;

endmodule

`default_nettype wire

//--- logic/uart_tx_serializer.sv
`timescale 1ns/10ps
`default_nettype none

module uart_tx_serializer (
	input logic clock_50,
	input logic rst_n,
	input board_io_pkg::tx_request_t tx_request,
	output logic uart_txd
);
	import board_io_pkg::*;

	tx_state_t state;
	bit_cnt_t bit_cnt;
	bit_idx_t bit_idx;
	logic bit_end;
	// Remaining data bits, LSB goes out next
	uart_byte_t shift_q;

	// Last cycle of the bit currently on the line
	assign bit_end = (bit_cnt == bit_cnt_t'(CLKS_PER_BIT - 1));

	always_ff @(posedge clock_50) begin
		if (!rst_n) begin
			state <= TX_IDLE;
			bit_cnt <= '0;
			bit_idx <= '0;
			uart_txd <= 1'b1;
		end else begin
			case (state)
				TX_IDLE: begin
					bit_cnt <= '0;
					bit_idx <= '0;
					uart_txd <= 1'b1;
					// Only idle takes a request
					if (tx_request.valid) begin
						uart_txd <= 1'b0;
						state <= TX_START;
					end
				end
				TX_START: begin
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_end) begin
						uart_txd <= shift_q[0];
						state <= TX_DATA;
					end
				end
				TX_DATA: begin
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_end) begin
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == bit_idx_t'(DATA_BITS - 1)) begin
							// Stop bit
							uart_txd <= 1'b1;
							state <= TX_STOP;
						end else begin
							uart_txd <= shift_q[0];
						end
					end
				end
				TX_STOP: begin
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_end) begin
						state <= TX_IDLE;
					end
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	// Load on accept, shift as each data bit goes out
	always_ff @(posedge clock_50) begin
		if (state == TX_IDLE && tx_request.valid) begin
			shift_q <= tx_request.data;
		end else if ((state == TX_START || state == TX_DATA) && bit_end) begin
			shift_q <= shift_q >> 1;
		end
	end

endmodule

`default_nettype wire

//--- logic/board_io_top.sv
`timescale 1ns/10ps
`default_nettype none

module board_io_top (
	input logic clock_50,
	input logic rst_n,
	input board_io_pkg::key_mask_t key,
	input board_io_pkg::switch_t sw,
	input logic uart_rxd,
	output logic uart_txd,
	output logic [board_io_pkg::LEDG_W-1:0] ledg,
	output board_io_pkg::switch_t ledr,
	output board_io_pkg::hex_bank_t hex
);
	import board_io_pkg::*;

	// Strobes between the blocks
	rx_event_t rx_event;
	key_event_t key_event;
	tx_request_t tx_request;

	// Serial receive side
	uart_rx_deframer u_rx (
		.clock_50 (clock_50),
		.rst_n (rst_n),
		.uart_rxd (uart_rxd),
		.rx_event (rx_event)
	);

	// KEY3 to KEY1
	key_press_capture u_keys (
		.clock_50 (clock_50),
		.rst_n (rst_n),
		.key (key),
		.key_event (key_event)
	);

	// Digits, LEDs and transmit requests
	display_controller u_display (
		.clock_50 (clock_50),
		.rst_n (rst_n),
		.rx_event (rx_event),
		.key_event (key_event),
		.sw (sw),
		.tx_request (tx_request),
		.hex (hex),
		.ledg (ledg),
		.ledr (ledr)
	);

	// Echo and switch byte go out here
	uart_tx_serializer u_tx (
		.clock_50 (clock_50),
		.rst_n (rst_n),
		.tx_request (tx_request),
		.uart_txd (uart_txd)
	);

endmodule

`default_nettype wire

//--- testbench/board_io_tb.sv
`timescale 1ns/10ps
`default_nettype none

module board_io_tb;
	import board_io_pkg::*;

	// Run limit in clock cycles
	localparam int TIMEOUT_CYCLES = 20 * 170 + 2000;
	localparam int FRAME_CYCLES = 10 * CLKS_PER_BIT;
	localparam int FRAME_GAP = 200;
	localparam int NUM_BYTES = 12;

	logic clock_50;
	logic rst_n;
	key_mask_t key;
	switch_t sw;
	logic uart_rxd;
	logic uart_txd;
	logic [LEDG_W-1:0] ledg;
	switch_t ledr;
	hex_bank_t hex;

	// Model of the display state
	digit_reg_t exp_digits;
	logic exp_err;
	uart_byte_t exp_last;
	switch_t exp_sw;

	// Bytes sent and bytes seen coming back
	uart_byte_t sent_q[$];
	uart_byte_t echo_q[$];

	int errors;
	int test_errors;
	int pass_tests;
	int fail_tests;
	int cycles;
	int seed;

	board_io_top UUT (
		.clock_50 (clock_50),
		.rst_n (rst_n),
		.key (key),
		.sw (sw),
		.uart_rxd (uart_rxd),
		.uart_txd (uart_txd),
		.ledg (ledg),
		.ledr (ledr),
		.hex (hex)
	);

	initial begin
		clock_50 = 1'b0;
		forever #2 clock_50 = ~clock_50;
	end

	// Lit segments in gfedcba order then inverted for the active-low pins
	function automatic seg7_t seg_ref(input hex_digit_t d);
		logic [6:0] lit;
		case (d)
			4'h0: lit = 7'h3f;
			4'h1: lit = 7'h06;
			4'h2: lit = 7'h5b;
			4'h3: lit = 7'h4f;
			4'h4: lit = 7'h66;
			4'h5: lit = 7'h6d;
			4'h6: lit = 7'h7d;
			4'h7: lit = 7'h07;
			4'h8: lit = 7'h7f;
			4'h9: lit = 7'h6f;
			4'ha: lit = 7'h77;
			4'hb: lit = 7'h7c;
			4'hc: lit = 7'h39;
			4'hd: lit = 7'h5e;
			4'he: lit = 7'h79;
			default: lit = 7'h71;
		endcase
		return ~lit;
	endfunction

	// Whole bank with HEX0 from the lowest nibble
	function automatic hex_bank_t hex_ref(input digit_reg_t digits);
		hex_bank_t bank;
		for (int i = 0; i < NUM_DIGITS; i++) begin
			bank[i*SEG_W +: SEG_W] = seg_ref(digits[i*HEX_W +: HEX_W]);
		end
		return bank;
	endfunction

	task automatic check_hex(input hex_bank_t got, input hex_bank_t exp, input string msg);
		if (got !== exp) begin
			$display("mismatch at %0t ns: %s, hex %h expected %h", $time, msg, got, exp);
			errors++;
		end
	endtask

	task automatic check_byte(input uart_byte_t got, input uart_byte_t exp, input string msg);
		if (got !== exp) begin
			$display("mismatch at %0t ns: %s, byte %h expected %h", $time, msg, got, exp);
			errors++;
		end
	endtask

	task automatic check_leds(input logic [LEDG_W-1:0] got_g, input logic [LEDG_W-1:0] exp_g,
			input switch_t got_r, input switch_t exp_r, input string msg);
		if (got_g !== exp_g || got_r !== exp_r) begin
			$display("mismatch at %0t ns: %s, ledg %h ledr %h expected ledg %h ledr %h",
				$time, msg, got_g, got_r, exp_g, exp_r);
			errors++;
		end
	endtask

	task automatic check_line(input logic got, input logic exp, input string msg);
		if (got !== exp) begin
			$display("mismatch at %0t ns: %s, uart_txd %b expected %b", $time, msg, got, exp);
			errors++;
		end
	endtask

	// Digits and LEDs against the model on the falling edge
	task automatic check_board(input string msg);
		@(negedge clock_50);
		check_hex(hex, hex_ref(exp_digits), msg);
		check_leds(ledg, {exp_err, exp_last}, ledr, exp_sw, msg);
	endtask

	// One 8N1 frame with an optional low stop bit
	task automatic send_frame(input uart_byte_t data, input logic bad_stop);
		logic [9:0] frame;
		frame = {~bad_stop, data, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(posedge clock_50);
			uart_rxd <= frame[i];
			repeat (CLKS_PER_BIT - 1) @(posedge clock_50);
		end
		// Back to idle
		@(posedge clock_50);
		uart_rxd <= 1'b1;
	endtask

	// Button held down for 8 cycles
	task automatic press_key(input int idx);
		@(posedge clock_50);
		key[idx] <= 1'b0;
		repeat (8) @(posedge clock_50);
		key[idx] <= 1'b1;
		repeat (4) @(posedge clock_50);
	endtask

	task automatic drive_sw(input switch_t value);
		@(posedge clock_50);
		sw <= value;
		exp_sw = value;
	endtask

	task automatic wait_echo(input uart_byte_t exp, input string msg);
		int waited;
		uart_byte_t got;
		waited = 0;
		while (echo_q.size() == 0 && waited < 2 * FRAME_CYCLES) begin
			@(negedge clock_50);
			waited++;
		end
		if (echo_q.size() == 0) begin
			$display("no frame appeared on uart_txd for %s", msg);
			errors++;
		end else begin
			got = echo_q.pop_front();
			check_byte(got, exp, msg);
		end
	endtask

	task automatic start_test();
		test_errors = errors;
	endtask

	task automatic end_test(input string name);
		if (errors == test_errors) begin
			pass_tests++;
			$display("test %s: passed", name);
		end else begin
			fail_tests++;
			$display("test %s: failed with %0d errors", name, errors - test_errors);
		end
	endtask

	// Frames on uart_txd sampled mid-bit
	always begin : echo_monitor
		uart_byte_t got;
		@(negedge clock_50);
		if (rst_n === 1'b1 && uart_txd === 1'b0) begin
			repeat (HALF_BIT) @(negedge clock_50);
			if (uart_txd !== 1'b0) begin
				$display("start bit on uart_txd did not stay low");
				errors++;
			end
			for (int i = 0; i < DATA_BITS; i++) begin
				repeat (CLKS_PER_BIT) @(negedge clock_50);
				got[i] = uart_txd;
			end
			repeat (CLKS_PER_BIT) @(negedge clock_50);
			if (uart_txd !== 1'b1) begin
				$display("frame on uart_txd ended with a low stop bit");
				errors++;
			end
			echo_q.push_back(got);
		end
	end

	initial begin : watchdog
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clock_50);
			cycles++;
		end
		$display("timeout: simulation ran past %0d clock cycles", TIMEOUT_CYCLES);
		$display("STATUS: FAIL");
		$finish;
	end

	initial begin : main_seq
		uart_byte_t b;
		uart_byte_t got;
		rst_n = 1'b0;
		key = '1;
		sw = '0;
		uart_rxd = 1'b1;
		exp_digits = '0;
		exp_err = 1'b0;
		exp_last = '0;
		exp_sw = '0;
		errors = 0;
		pass_tests = 0;
		fail_tests = 0;
		seed = 32'h5acb;
		repeat (10) @(posedge clock_50);
		rst_n <= 1'b1;
		repeat (2) @(posedge clock_50);

		// Idle board after reset
		start_test();
		check_board("after reset");
		check_line(uart_txd, 1'b1, "idle line after reset");
		end_test("reset state");

		// Newest byte lands in HEX1 and HEX0
		start_test();
		for (int i = 0; i < NUM_BYTES; i++) begin
			b = uart_byte_t'($random(seed));
			send_frame(b, 1'b0);
			exp_digits = {exp_digits[23:0], b};
			exp_last = b;
			sent_q.push_back(b);
			check_board($sformatf("received byte %0d", i));
			repeat (FRAME_GAP) @(posedge clock_50);
		end
		end_test("byte display");

		// Echoes in send order
		start_test();
		if (echo_q.size() != sent_q.size()) begin
			$display("expected %0d echo frames but saw %0d", sent_q.size(), echo_q.size());
			errors++;
		end
		while (echo_q.size() > 0 && sent_q.size() > 0) begin
			got = echo_q.pop_front();
			check_byte(got, sent_q.pop_front(), "echo byte");
		end
		end_test("echo");

		// Switch mirror with key 2 load and key 3 send
		start_test();
		for (int i = 0; i < 4; i++) begin
			drive_sw(switch_t'($random(seed)));
			repeat (2) @(posedge clock_50);
			check_board($sformatf("switch value %0d", i));
		end
		// Upper digits still hold received bytes here
		press_key(KEY_LOAD);
		exp_digits[15:0] = exp_sw[15:0];
		check_board("key 2 load");
		press_key(KEY_SEND);
		wait_echo(exp_sw[7:0], "key 3 send");
		end_test("switches and keys");

		// Bad stop bit followed by key 1
		start_test();
		send_frame(uart_byte_t'($random(seed)), 1'b1);
		exp_err = 1'b1;
		check_board("framing error");
		repeat (20) @(posedge clock_50);
		press_key(KEY_CLEAR);
		exp_digits = '0;
		exp_err = 1'b0;
		check_board("key 1 clear");
		repeat (FRAME_CYCLES) @(posedge clock_50);
		if (echo_q.size() != 0) begin
			$display("a frame was sent back for a byte with a framing error");
			errors++;
			echo_q.delete();
		end
		end_test("framing error and clear");

		$display("tests passed %0d failed %0d", pass_tests, fail_tests);
		if (fail_tests == 0 && errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- board_io_top.f
logic/board_io_pkg.sv
logic/uart_rx_deframer.sv
logic/key_press_capture.sv
logic/display_controller.sv
logic/uart_tx_serializer.sv
logic/board_io_top.sv
testbench/board_io_tb.sv

//--- Makefile
# Verilator build and run for the board I/O testbench

TOP ?= board_io_tb
FILELIST ?= board_io_top.f
VERILATOR ?= verilator
BUILD_DIR ?= build
LOG ?= sim.log

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) --binary --timing --timescale 1ns/10ps \
		--top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: compile
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "STATUS: PASS" $(LOG) || (echo "simulation did not pass" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
